/* neoSoundPkg.sv */
`default_nettype none

package neoSoundPkg;

	// Z80 side widths
	typedef logic [15:0] z80Addr;
	typedef logic [7:0] z80Data;

	// Bank number latched from A15..A8 on a bank port read
	typedef logic [7:0] bankNum;

	// Extended sound ROM address with 4 MB reach
	typedef logic [21:0] romAddr;

	localparam int NUM_WINDOWS = 4;
	localparam int WIN_SEL_BITS = $clog2(NUM_WINDOWS);	// A1..A0 on a bank port

	// Window 0 sits just under the work RAM, window 3 is the big one
	localparam z80Addr windowBase [NUM_WINDOWS] = '{
		16'hF000,
		16'hE000,
		16'hC000,
		16'h8000
	};
	localparam int windowShift [NUM_WINDOWS] = '{11, 12, 13, 14};	// 2, 4, 8, 16 KB

	localparam z80Addr RAM_BASE = 16'hF800;	// Work RAM up to $FFFF

	localparam int PORT_SEL_LSB = 2;	// A3..A2 pick the port group
	localparam int NMI_EN_BIT = 4;		// A4 carries the NMI enable value
	localparam int ADDR_HIGH_LSB = 8;	// Bank number field in the address

	// Port groups by A3..A2
	typedef enum logic [1:0] {
		CMD_PORT = 2'b00,		// $x0..$x3, command read, reply clear
		YM_PORT = 2'b01,		// $x4..$x7, YM2610
		BANK_PORT = 2'b10,		// $x8..$xB, bank read, NMI enable write
		REPLY_PORT = 2'b11		// $xC..$xF, reply write
	} portGroup;

endpackage

`default_nettype wire

/* z80PortIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface z80PortIf
	import neoSoundPkg::*;
();

	// One-cycle access start pulses
	logic cmdRdStart;		// Read of $x0..$x3
	logic clrWrStart;		// Write to $x0..$x3
	logic replyWrStart;		// Write to $xC..$xF
	logic nmiEnWrStart;		// Write to $x8..$xB
	logic [NUM_WINDOWS-1:0] bankRdStart;	// Read of $x8 + window

	// Payload valid alongside the pulses
	bankNum addrHigh;		// A15..A8
	logic addrBit4;		// NMI enable value
	z80Data wrData;		// Z80 write data

	// Decoder side
	modport decode (
		output cmdRdStart, clrWrStart, replyWrStart, nmiEnWrStart,
		output bankRdStart,
		output addrHigh, addrBit4, wrData
	);

	// Command port and bank registers
	modport sink (
		input cmdRdStart, clrWrStart, replyWrStart, nmiEnWrStart,
		input bankRdStart,
		input addrHigh, addrBit4, wrData
	);

endinterface

`default_nettype wire

/* z80PortDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module z80PortDecode
	import neoSoundPkg::*;
(
	input wire logic CLK_4M,
	input wire logic nRESET,
	input wire z80Addr sdAddr,
	input wire z80Data sdDataIn,
	input wire logic nSdRd,
	input wire logic nSdWr,
	input wire logic nMreq,
	input wire logic nIorq,
	output logic nSdRom,
	output logic nZramCs,
	output logic nSdMrd,
	output logic nSdMwr,
	output logic n2610Cs,
	output logic n2610Rd,
	output logic n2610Wr,
	z80PortIf.decode port
);

	portGroup group;		// Port group from A3..A2
	logic ioRd;			// I/O read in progress
	logic ioWr;			// I/O write in progress
	logic ioRdPrev;		// Level seen at the last edge
	logic ioWrPrev;
	logic rdStart;		// First cycle of an I/O read
	logic wrStart;		// First cycle of an I/O write
	logic bankGroup;

	// $0000..$F7FF ROM, $F800..$FFFF work RAM
	assign nSdRom = (sdAddr >= RAM_BASE);
	assign nZramCs = ~nSdRom;

	// Memory strobes
	assign nSdMrd = nMreq | nSdRd;
	assign nSdMwr = nMreq | nSdWr;

	assign group = portGroup'(sdAddr[PORT_SEL_LSB +: 2]);

	// YM2610 on $x4..$x7 for any access
	assign n2610Cs = nIorq | (group != YM_PORT);
	assign n2610Rd = nIorq | nSdRd;
	assign n2610Wr = nIorq | nSdWr;

	// I/O cycle levels
	assign ioRd = ~nIorq & ~nSdRd;
	assign ioWr = ~nIorq & ~nSdWr;

	// Previous levels for edge detection
	always_ff @(posedge CLK_4M)
	begin
		if (!nRESET)
		begin
			ioRdPrev <= 1'b0;
			ioWrPrev <= 1'b0;
		end
		else
		begin
			ioRdPrev <= ioRd;
			ioWrPrev <= ioWr;
		end
	end

	// High only in the cycle before the first edge of the access
	assign rdStart = ioRd & ~ioRdPrev;
	assign wrStart = ioWr & ~ioWrPrev;

	assign bankGroup = (group == BANK_PORT);

	// Route the pulses to their groups
	assign port.cmdRdStart = rdStart & (group == CMD_PORT);	// Also NMI ack
	assign port.clrWrStart = wrStart & (group == CMD_PORT);	// Reply clear
	assign port.replyWrStart = wrStart & (group == REPLY_PORT);
	assign port.nmiEnWrStart = wrStart & bankGroup;

	// One bit per window picked by A1..A0
	always_comb
	begin
		port.bankRdStart = '0;
		if (rdStart && bankGroup)
			port.bankRdStart = NUM_WINDOWS'(1) << sdAddr[WIN_SEL_BITS-1:0];
	end

	// Payload straight off the bus
	assign port.addrHigh = sdAddr[ADDR_HIGH_LSB +: $bits(bankNum)];
	assign port.addrBit4 = sdAddr[NMI_EN_BIT];
	assign port.wrData = sdDataIn;

	// Read and write strobes low together would fire two consumers at once
	startOneHot: assert property (
		@(posedge CLK_4M) disable iff (!nRESET)
		$onehot0({port.cmdRdStart, port.clrWrStart, port.replyWrStart,
			port.nmiEnWrStart, port.bankRdStart})
	)
	else
		$error("Overlapping access starts, addr %h", sdAddr);

endmodule

`default_nettype wire

/* z80CommandPort.sv */
`timescale 1ns/1ps
`default_nettype none

module z80CommandPort
	import neoSoundPkg::*;
(
	input wire logic CLK_4M,
	input wire logic nRESET,
	input wire logic cpuCmdWr,		// One-cycle strobe from the main CPU
	input wire z80Data cpuCmd,
	output z80Data cpuReply,
	output z80Data cmdLatch,
	output logic nZ80Nmi,
	z80PortIf.sink port
);

	logic nmiEn;		// Set by A4 on a bank port write

	// Command from the main CPU without back-pressure
	always_ff @(posedge CLK_4M)
	begin
		if (!nRESET)
			cmdLatch <= '0;
		else if (cpuCmdWr)
			cmdLatch <= cpuCmd;		// Overwrites an unread command
	end

	// Reply back to the main CPU
	always_ff @(posedge CLK_4M)
	begin
		if (!nRESET)
			cpuReply <= '0;
		else if (port.replyWrStart)
			cpuReply <= port.wrData;		// $xC..$xF write
		else if (port.clrWrStart)
			cpuReply <= '0;		// $x0..$x3 write
	end

	// NMI enable
	always_ff @(posedge CLK_4M)
	begin
		if (!nRESET)
			nmiEn <= 1'b0;		// Disabled out of reset
		else if (port.nmiEnWrStart)
			nmiEn <= port.addrBit4;
	end

	// Set on a command, ack on a command port read
	always_ff @(posedge CLK_4M)
	begin
		if (!nRESET)
		begin
			nZ80Nmi <= 1'b1;
		end
		else
		begin
			if (port.cmdRdStart)
				nZ80Nmi <= 1'b1;		// Ack wins a tie
			else if (cpuCmdWr && nmiEn)
				nZ80Nmi <= 1'b0;
		end
	end

	// NMI only asserts if enabled at the edge before
	nmiNeedsEnable: assert property (
		@(posedge CLK_4M) disable iff (!nRESET)
		$fell(nZ80Nmi) |-> $past(nmiEn)
	)
	else
		$error("NMI asserted while disabled");

endmodule

`default_nettype wire

/* zmcBankReg.sv */
`timescale 1ns/1ps
`default_nettype none

module zmcBankReg
	import neoSoundPkg::*;
#(
	parameter int windowIdx = 0		// 0 is $F000, 3 is $8000
)(
	input wire logic CLK_4M,
	input wire logic nRESET,
	output bankNum bank,
	z80PortIf.sink port
);

	logic load;

	// This window's port is $x8 + windowIdx
	assign load = port.bankRdStart[windowIdx];

	// Bank number rides on A15..A8 of the read
	always_ff @(posedge CLK_4M)
	begin
		if (!nRESET)
			bank <= '0;
		else if (load)
			bank <= port.addrHigh;
	end

	// Only windows 0..3 exist
	if (windowIdx < 0 || windowIdx >= NUM_WINDOWS)
	begin : badIdx
		$error("windowIdx %0d out of range", windowIdx);
	end

endmodule

`default_nettype wire

/* zmcAddrMux.sv */
`timescale 1ns/1ps
`default_nettype none

module zmcAddrMux
	import neoSoundPkg::*;
(
	input wire z80Addr sdAddr,
	input wire bankNum banks [NUM_WINDOWS],
	output romAddr romAddrOut
);

	logic hit;		// Address is in a window
	logic [WIN_SEL_BITS-1:0] sel;	// Which one

	// Bases fall with the index, so the last hit is the highest base
	always_comb
	begin
		hit = 1'b0;
		sel = '0;
		for (int i = NUM_WINDOWS - 1; i >= 0; i--)
		begin
			if (sdAddr >= windowBase[i])
			begin
				hit = 1'b1;
				sel = WIN_SEL_BITS'(i);
			end
		end
	end

	// Bank above, offset below
	always_comb
	begin
		romAddr winMask;
		romAddr bankPart;
		winMask = (romAddr'(1) << windowShift[sel]) - romAddr'(1);
		bankPart = romAddr'(banks[sel]) << windowShift[sel];
		if (hit)
			romAddrOut = bankPart + (romAddr'(sdAddr) & winMask);	// RAM range lands in window 0
		else
			romAddrOut = romAddr'(sdAddr);		// $0000..$7FFF fixed
	end

endmodule

`default_nettype wire

/* neoSoundCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module neoSoundCtrl
	import neoSoundPkg::*;
(
	input wire logic CLK_4M,
	input wire logic nRESET,

	// Z80 bus
	input wire z80Addr sdAddr,
	input wire z80Data sdDataIn,
	input wire logic nSdRd,
	input wire logic nSdWr,
	input wire logic nMreq,
	input wire logic nIorq,

	// Main CPU side
	input wire logic cpuCmdWr,
	input wire z80Data cpuCmd,
	output z80Data cpuReply,

	// Z80 and board
	output z80Data sdDataOut,
	output logic nZ80Nmi,
	output logic nSdRom,
	output logic nZramCs,
	output logic nSdMrd,
	output logic nSdMwr,
	output logic n2610Cs,
	output logic n2610Rd,
	output logic n2610Wr,
	output romAddr romAddrOut
);

	z80PortIf portBus();
	z80Data cmdLatch;
	bankNum banks [NUM_WINDOWS];

	z80PortDecode i_z80PortDecode (
		.CLK_4M (CLK_4M),
		.nRESET (nRESET),
		.sdAddr (sdAddr),
		.sdDataIn (sdDataIn),
		.nSdRd (nSdRd),
		.nSdWr (nSdWr),
		.nMreq (nMreq),
		.nIorq (nIorq),
		.nSdRom (nSdRom),
		.nZramCs (nZramCs),
		.nSdMrd (nSdMrd),
		.nSdMwr (nSdMwr),
		.n2610Cs (n2610Cs),
		.n2610Rd (n2610Rd),
		.n2610Wr (n2610Wr),
		.port (portBus)
	);

	z80CommandPort i_z80CommandPort (
		.CLK_4M (CLK_4M),
		.nRESET (nRESET),
		.cpuCmdWr (cpuCmdWr),
		.cpuCmd (cpuCmd),
		.cpuReply (cpuReply),
		.cmdLatch (cmdLatch),
		.nZ80Nmi (nZ80Nmi),
		.port (portBus)
	);

	// One register per window
	for (genvar i = 0; i < NUM_WINDOWS; i++)
	begin : gBank
		zmcBankReg #(.windowIdx(i)) i_zmcBankReg (
			.CLK_4M (CLK_4M),
			.nRESET (nRESET),
			.bank (banks[i]),
			.port (portBus)
		);
	end

	zmcAddrMux i_zmcAddrMux (
		.sdAddr (sdAddr),
		.banks (banks),
		.romAddrOut (romAddrOut)
	);

	// Command latch onto the Z80 bus for $x0..$x3 reads
	assign sdDataOut = (!nIorq && !nSdRd &&
		(portGroup'(sdAddr[PORT_SEL_LSB +: 2]) == CMD_PORT)) ? cmdLatch : '0;

endmodule

`default_nettype wire

/* tb_neoSoundCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_neoSoundCtrl
	import neoSoundPkg::*;
();

	localparam int TIMEOUT_CYCLES = 3000;	// About twice the tests' length

	logic clk;
	logic nRESET;
	z80Addr sdAddr;
	z80Data sdDataIn;
	logic nSdRd;
	logic nSdWr;
	logic nMreq;
	logic nIorq;
	logic cpuCmdWr;
	z80Data cpuCmd;
	z80Data cpuReply;
	z80Data sdDataOut;
	logic nZ80Nmi;
	logic nSdRom;
	logic nZramCs;
	logic nSdMrd;
	logic nSdMwr;
	logic n2610Cs;
	logic n2610Rd;
	logic n2610Wr;
	romAddr romAddrOut;

	// Reference model state updated on falling edges
	z80Data expCmd;
	z80Data expReply;
	logic expNmi;
	logic nmiEn;
	bankNum expBank [4];

	logic [31:0] lfsr;
	int errCount;
	int testCount;
	int errAtStart;
	int cycleCount;

	neoSoundCtrl i_neoSoundCtrl (
		.CLK_4M (clk),
		.nRESET (nRESET),
		.sdAddr (sdAddr),
		.sdDataIn (sdDataIn),
		.nSdRd (nSdRd),
		.nSdWr (nSdWr),
		.nMreq (nMreq),
		.nIorq (nIorq),
		.cpuCmdWr (cpuCmdWr),
		.cpuCmd (cpuCmd),
		.cpuReply (cpuReply),
		.sdDataOut (sdDataOut),
		.nZ80Nmi (nZ80Nmi),
		.nSdRom (nSdRom),
		.nZramCs (nZramCs),
		.nSdMrd (nSdMrd),
		.nSdMwr (nSdMwr),
		.n2610Cs (n2610Cs),
		.n2610Rd (n2610Rd),
		.n2610Wr (n2610Wr),
		.romAddrOut (romAddrOut)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;		// 20 ns period
	end

	// Taps 32, 22, 2, 1; one step per bit taken
	function automatic logic [31:0] lfsrTake(input int nBits);
		logic [31:0] bits;
		logic fb;
		bits = '0;
		for (int i = 0; i < nBits; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	// Window rule with bank above, offset below and the low 32 KB fixed
	function automatic logic [21:0] expRomAddr(input logic [15:0] addr);
		int w;
		int shift;
		logic [21:0] offset;
		if (addr < 16'h8000)
			return {6'b0, addr};
		if (addr >= 16'hF000)
		begin
			w = 0;
			shift = 11;		// RAM range falls in here too
		end
		else if (addr >= 16'hE000)
		begin
			w = 1;
			shift = 12;
		end
		else if (addr >= 16'hC000)
		begin
			w = 2;
			shift = 13;
		end
		else
		begin
			w = 3;
			shift = 14;
		end
		offset = {6'b0, addr} & ((22'd1 << shift) - 22'd1);
		return ({14'b0, expBank[w]} << shift) + offset;
	endfunction

	task automatic reportMismatch(input string sigName, input logic [31:0] expVal,
		input logic [31:0] gotVal);
		$display("Fail %s expected %h got %h at %0t", sigName, expVal, gotVal, $time);
		errCount++;
	endtask

	task automatic endTest(input string name);
		$display("Test %s done, %0d mismatches", name, errCount - errAtStart);
		testCount++;
		errAtStart = errCount;
	endtask

	task automatic memRead(input z80Addr addr);
		@(negedge clk);
		sdAddr = addr;
		nMreq = 1'b0;
		nSdRd = 1'b0;
		@(negedge clk);
		nMreq = 1'b1;
		nSdRd = 1'b1;
	endtask

	task automatic memWrite(input z80Addr addr, input z80Data data);
		@(negedge clk);
		sdAddr = addr;
		sdDataIn = data;
		nMreq = 1'b0;
		nSdWr = 1'b0;
		@(negedge clk);
		nMreq = 1'b1;
		nSdWr = 1'b1;
	endtask

	// Two cycles of strobes, one idle; effects land on the first edge
	task automatic ioRead(input z80Addr addr);
		@(negedge clk);
		sdAddr = addr;
		nIorq = 1'b0;
		nSdRd = 1'b0;
		@(negedge clk);
		if (addr[3:2] == 2'b00)
			expNmi = 1'b1;		// NMI ack
		if (addr[3:2] == 2'b10)
			expBank[addr[1:0]] = addr[15:8];
		@(negedge clk);
		nIorq = 1'b1;
		nSdRd = 1'b1;
	endtask

	task automatic ioWrite(input z80Addr addr, input z80Data data);
		@(negedge clk);
		sdAddr = addr;
		sdDataIn = data;
		nIorq = 1'b0;
		nSdWr = 1'b0;
		@(negedge clk);
		case (addr[3:2])
			2'b00: expReply = 8'h00;
			2'b10: nmiEn = addr[4];
			2'b11: expReply = data;
			default: ;		// YM2610 only
		endcase
		@(negedge clk);
		nIorq = 1'b1;
		nSdWr = 1'b1;
	endtask

	task automatic cmdWrite(input z80Data data);
		@(negedge clk);
		cpuCmdWr = 1'b1;
		cpuCmd = data;
		@(negedge clk);
		cpuCmdWr = 1'b0;
		expCmd = data;		// Latch loads regardless
		if (nmiEn)
			expNmi = 1'b0;
	endtask

	chkRom: assert property (@(posedge clk) disable iff (!nRESET)
		nSdRom == (sdAddr >= 16'hF800))
		else reportMismatch("nSdRom", $sampled(sdAddr >= 16'hF800), $sampled(nSdRom));
	chkRam: assert property (@(posedge clk) disable iff (!nRESET)
		nZramCs == (sdAddr < 16'hF800))
		else reportMismatch("nZramCs", $sampled(sdAddr < 16'hF800), $sampled(nZramCs));
	chkMrd: assert property (@(posedge clk) disable iff (!nRESET) nSdMrd == (nMreq | nSdRd))
		else reportMismatch("nSdMrd", $sampled(nMreq | nSdRd), $sampled(nSdMrd));
	chkMwr: assert property (@(posedge clk) disable iff (!nRESET) nSdMwr == (nMreq | nSdWr))
		else reportMismatch("nSdMwr", $sampled(nMreq | nSdWr), $sampled(nSdMwr));
	chkYmCs: assert property (@(posedge clk) disable iff (!nRESET)
		n2610Cs == (nIorq | (sdAddr[3:2] != 2'b01)))		// $x4..$x7
		else reportMismatch("n2610Cs", $sampled(nIorq | (sdAddr[3:2] != 2'b01)),
			$sampled(n2610Cs));
	chkYmRd: assert property (@(posedge clk) disable iff (!nRESET) n2610Rd == (nIorq | nSdRd))
		else reportMismatch("n2610Rd", $sampled(nIorq | nSdRd), $sampled(n2610Rd));
	chkYmWr: assert property (@(posedge clk) disable iff (!nRESET) n2610Wr == (nIorq | nSdWr))
		else reportMismatch("n2610Wr", $sampled(nIorq | nSdWr), $sampled(n2610Wr));
	chkData: assert property (@(posedge clk) disable iff (!nRESET)
		sdDataOut == ((!nIorq && !nSdRd && sdAddr[3:2] == 2'b00) ? expCmd : 8'h00))
		else reportMismatch("sdDataOut",
			$sampled((!nIorq && !nSdRd && sdAddr[3:2] == 2'b00) ? expCmd : 8'h00),
			$sampled(sdDataOut));
	chkNmi: assert property (@(posedge clk) disable iff (!nRESET) nZ80Nmi == expNmi)
		else reportMismatch("nZ80Nmi", $sampled(expNmi), $sampled(nZ80Nmi));
	chkReply: assert property (@(posedge clk) disable iff (!nRESET) cpuReply == expReply)
		else reportMismatch("cpuReply", $sampled(expReply), $sampled(cpuReply));
	chkRomAddr: assert property (@(posedge clk) disable iff (!nRESET)
		romAddrOut == expRomAddr(sdAddr))
		else reportMismatch("romAddrOut", expRomAddr($sampled(sdAddr)), $sampled(romAddrOut));

	// Watchdog
	initial
	begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Run stopped after %0d cycles without finishing the tests", cycleCount);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		z80Addr addr;
		lfsr = 32'h10a3_99b4;
		errCount = 0;
		testCount = 0;
		errAtStart = 0;
		nRESET = 1'b0;
		sdAddr = '0;
		sdDataIn = '0;
		nSdRd = 1'b1;		// Bus idle
		nSdWr = 1'b1;
		nMreq = 1'b1;
		nIorq = 1'b1;
		cpuCmdWr = 1'b0;
		cpuCmd = '0;
		expCmd = '0;
		expReply = '0;
		expNmi = 1'b1;
		nmiEn = 1'b0;
		for (int w = 0; w < 4; w++)
			expBank[w] = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		nRESET = 1'b1;

		repeat (200)		// Random ROM and RAM traffic
		begin
			memRead(z80Addr'(lfsrTake(16)));
			addr = z80Addr'(lfsrTake(16));
			memWrite(addr, z80Data'(lfsrTake(8)));
		end
		endTest("memDecode");

		for (int i = 0; i < 32; i++)
		begin
			addr = z80Addr'(lfsrTake(16));
			if (i < 8)
				addr[3:2] = 2'b01;		// Make sure the YM2610 gets hit
			ioWrite(addr, z80Data'(lfsrTake(8)));
			ioRead(addr);
		end
		endTest("ymPort");

		ioWrite({z80Data'(lfsrTake(8)), 8'h18}, z80Data'(lfsrTake(8)));	// A4 set
		repeat (8)
		begin
			cmdWrite(z80Data'(lfsrTake(8)));
			ioRead({12'(lfsrTake(12)), 4'h0});		// Read back and ack
		end
		endTest("nmiEnabled");

		ioWrite({z80Data'(lfsrTake(8)), 8'h08}, z80Data'(lfsrTake(8)));	// A4 clear
		repeat (8)
			cmdWrite(z80Data'(lfsrTake(8)));
		ioRead({12'(lfsrTake(12)), 4'h0});
		endTest("nmiDisabled");

		repeat (8)
		begin
			ioWrite({12'(lfsrTake(12)), 4'hC}, z80Data'(lfsrTake(8)));
			ioWrite({12'(lfsrTake(12)), 4'h0}, z80Data'(lfsrTake(8)));	// Clear
		end
		endTest("replyLatch");

		for (int w = 0; w < 4; w++)
		begin
			ioRead({z80Data'(lfsrTake(8)), 4'(lfsrTake(4)), 2'b10, 2'(w)});
			repeat (16)
			begin
				case (w)
					0: addr = 16'hF000 + z80Addr'(lfsrTake(11));
					1: addr = 16'hE000 + z80Addr'(lfsrTake(12));
					2: addr = 16'hC000 + z80Addr'(lfsrTake(13));
					default: addr = 16'h8000 + z80Addr'(lfsrTake(14));
				endcase
				memRead(addr);
			end
		end
		repeat (16)
			memRead({1'b0, 15'(lfsrTake(15))});		// Fixed low 32 KB
		endTest("bankSwitch");

		@(negedge clk);
		$display("Tests run %0d, mismatches %0d", testCount, errCount);
		if (errCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
neoSoundPkg.sv
z80PortIf.sv
z80PortDecode.sv
z80CommandPort.sv
zmcBankReg.sv
zmcAddrMux.sv
neoSoundCtrl.sv
tb_neoSoundCtrl.sv
